/* build.f */
+incdir+sim
design/kme_tlv_pkg.sv
design/tlv_router.sv
design/gcm_cmd_builder.sv
design/gcm_tag_builder.sv
design/kme_tlv_inspector.sv
sim/tb_kme_tlv_inspector.sv

/* design/gcm_cmd_builder.sv */
// Builds the DEK and DAK GCM commands from accepted beats.
// WORD0 clears both commands and loads their ops from the key type; CKV beats
// shift into the key fields; the second IV beat completes a command, which is
// emitted in that same cycle with the beat folded in.
`timescale 1ns/1ps

module gcm_cmd_builder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  kme_tlv_pkg::tlv_beat_t      beat,
    input  logic                        beat_take,
    output kme_tlv_pkg::gcm_cmd_t       gcm_cmd,
    output logic                        gcm_cmd_valid
);

    localparam int KEEP_W = kme_tlv_pkg::KEY_W - kme_tlv_pkg::TDATA_W;
    localparam int IV_LO_W = kme_tlv_pkg::IV_W - kme_tlv_pkg::TDATA_W;  // 32

    kme_tlv_pkg::tlv_word0_t word0;
    kme_tlv_pkg::gcm_op_e    dek_op;
    kme_tlv_pkg::gcm_op_e    dak_op;
    kme_tlv_pkg::gcm_cmd_t   dek_cmd;
    kme_tlv_pkg::gcm_cmd_t   dak_cmd;
    kme_tlv_pkg::gcm_cmd_t   dek_nxt;
    kme_tlv_pkg::gcm_cmd_t   dak_nxt;
    logic                    iv_done;

    // key type decode, one table per command
    always_comb begin
        word0 = beat.tdata;
        case (word0.key_type)
            kme_tlv_pkg::NO_AUX_KEY:          dek_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::AUX_KEY_ONLY:        dek_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::DEK256:              dek_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::DEK512:              dek_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::DAK:                 dek_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::DEK256_DAK:          dek_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::DEK512_DAK:          dek_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::ENC_DEK256:          dek_op = kme_tlv_pkg::DECRYPT_DEK256;
            kme_tlv_pkg::ENC_DEK512:          dek_op = kme_tlv_pkg::DECRYPT_DEK512;
            kme_tlv_pkg::ENC_DAK:             dek_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::ENC_DEK256_DAK:      dek_op = kme_tlv_pkg::DECRYPT_DEK256;
            kme_tlv_pkg::ENC_DEK512_DAK:      dek_op = kme_tlv_pkg::DECRYPT_DEK512;
            kme_tlv_pkg::ENC_DEK256_DAK_COMB: dek_op = kme_tlv_pkg::DECRYPT_DEK256_COMB;
            kme_tlv_pkg::ENC_DEK512_DAK_COMB: dek_op = kme_tlv_pkg::DECRYPT_DEK512_COMB;
            default:                          dek_op = kme_tlv_pkg::PT_KEY_BLOB;
        endcase
        case (word0.key_type)
            kme_tlv_pkg::NO_AUX_KEY:          dak_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::AUX_KEY_ONLY:        dak_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::DEK256:              dak_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::DEK512:              dak_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::DAK:                 dak_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::DEK256_DAK:          dak_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::DEK512_DAK:          dak_op = kme_tlv_pkg::PT_KEY_BLOB;
            kme_tlv_pkg::ENC_DEK256:          dak_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::ENC_DEK512:          dak_op = kme_tlv_pkg::PT_CKV;
            kme_tlv_pkg::ENC_DAK:             dak_op = kme_tlv_pkg::DECRYPT_DAK;
            kme_tlv_pkg::ENC_DEK256_DAK:      dak_op = kme_tlv_pkg::DECRYPT_DAK;
            kme_tlv_pkg::ENC_DEK512_DAK:      dak_op = kme_tlv_pkg::DECRYPT_DAK;
            kme_tlv_pkg::ENC_DEK256_DAK_COMB: dak_op = kme_tlv_pkg::DECRYPT_DAK_COMB;
            kme_tlv_pkg::ENC_DEK512_DAK_COMB: dak_op = kme_tlv_pkg::DECRYPT_DAK_COMB;
            default:                          dak_op = kme_tlv_pkg::PT_KEY_BLOB;
        endcase
    end

    // next-state of both commands, untouched unless a beat is taken
    always_comb begin
        dek_nxt = dek_cmd;
        dak_nxt = dak_cmd;
        if (beat_take) begin
            case (beat.id)
                kme_tlv_pkg::KME_WORD0: begin
                    dek_nxt    = '0;
                    dak_nxt    = '0;
                    dek_nxt.op = dek_op;
                    dak_nxt.op = dak_op;
                end
                kme_tlv_pkg::KME_DEK_CKV0: dek_nxt.key0 = {dek_cmd.key0[KEEP_W-1:0], beat.tdata};
                kme_tlv_pkg::KME_DEK_CKV1: dek_nxt.key1 = {dek_cmd.key1[KEEP_W-1:0], beat.tdata};
                kme_tlv_pkg::KME_DAK_CKV: begin
                    // dak key lands in both halves
                    dak_nxt.key0 = {dak_cmd.key0[KEEP_W-1:0], beat.tdata};
                    dak_nxt.key1 = {dak_cmd.key1[KEEP_W-1:0], beat.tdata};
                end
                kme_tlv_pkg::KME_EIV: begin
                    if (beat.eoi)
                        dek_nxt.iv[IV_LO_W-1:0] = beat.tdata[kme_tlv_pkg::TDATA_W-1 -: IV_LO_W];
                    else
                        dek_nxt.iv[kme_tlv_pkg::IV_W-1:IV_LO_W] = beat.tdata;
                end
                kme_tlv_pkg::KME_AIV: begin
                    if (beat.eoi)
                        dak_nxt.iv[IV_LO_W-1:0] = beat.tdata[kme_tlv_pkg::TDATA_W-1 -: IV_LO_W];
                    else
                        dak_nxt.iv[kme_tlv_pkg::IV_W-1:IV_LO_W] = beat.tdata;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dek_cmd <= '0;
            dak_cmd <= '0;
        end else begin
            dek_cmd <= dek_nxt;
            dak_cmd <= dak_nxt;
        end
    end

    assign iv_done = beat_take & beat.eoi &
                     ((beat.id == kme_tlv_pkg::KME_EIV) | (beat.id == kme_tlv_pkg::KME_AIV));
    assign gcm_cmd_valid = iv_done;

    always_comb begin
        gcm_cmd = '0;
        if (iv_done)
            gcm_cmd = (beat.id == kme_tlv_pkg::KME_EIV) ? dek_nxt : dak_nxt;
    end

endmodule

/* design/gcm_tag_builder.sv */
// Assembles the 96-bit DEK and DAK authentication tags from two beats each.
// The first beat fills the upper 64 bits, the eoi beat the low 32 from its top half.
// The finished tag is emitted in the cycle its closing beat is accepted.
`timescale 1ns/1ps

module gcm_tag_builder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  kme_tlv_pkg::tlv_beat_t          beat,
    input  logic                            beat_take,
    output logic [kme_tlv_pkg::TAG_W-1:0]   gcm_tag,
    output logic                            gcm_tag_valid
);

    localparam int LO_W = kme_tlv_pkg::TAG_W - kme_tlv_pkg::TDATA_W;

    logic [kme_tlv_pkg::TAG_W-1:0] dek_tag;
    logic [kme_tlv_pkg::TAG_W-1:0] dak_tag;
    logic [kme_tlv_pkg::TAG_W-1:0] dek_nxt;
    logic [kme_tlv_pkg::TAG_W-1:0] dak_nxt;
    logic                          is_etag;
    logic                          is_atag;

    assign is_etag = beat_take & (beat.id == kme_tlv_pkg::KME_ETAG);
    assign is_atag = beat_take & (beat.id == kme_tlv_pkg::KME_ATAG);

    always_comb begin
        dek_nxt = dek_tag;
        dak_nxt = dak_tag;
        if (is_etag && beat.eoi)
            dek_nxt[LO_W-1:0] = beat.tdata[kme_tlv_pkg::TDATA_W-1 -: LO_W];
        else if (is_etag)
            dek_nxt[kme_tlv_pkg::TAG_W-1:LO_W] = beat.tdata;
        if (is_atag && beat.eoi)
            dak_nxt[LO_W-1:0] = beat.tdata[kme_tlv_pkg::TDATA_W-1 -: LO_W];
        else if (is_atag)
            dak_nxt[kme_tlv_pkg::TAG_W-1:LO_W] = beat.tdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dek_tag <= '0;
            dak_tag <= '0;
        end else begin
            dek_tag <= dek_nxt;
            dak_tag <= dak_nxt;
        end
    end

    assign gcm_tag_valid = (is_etag | is_atag) & beat.eoi;
    assign gcm_tag = !gcm_tag_valid ? '0 : (is_etag ? dek_nxt : dak_nxt);

endmodule

/* design/kme_tlv_inspector.sv */
// Top level of the KME TLV inspector stage.
// Takes tagged 64-bit beats with a valid/ack handshake and fans them out to
// the GCM command, GCM tag, key upsizer and sideband outputs, each with
// valid/stall. Outputs are combinational from the accepted beat.
`timescale 1ns/1ps

module kme_tlv_inspector (
    input  logic                                clk,
    input  logic                                rst_n,
    input  kme_tlv_pkg::tlv_beat_t              beat,
    input  logic                                beat_valid,
    output logic                                beat_ack,
    output kme_tlv_pkg::gcm_cmd_t               gcm_cmd,
    output logic                                gcm_cmd_valid,
    input  logic                                gcm_cmd_stall,
    output logic [kme_tlv_pkg::TAG_W-1:0]       gcm_tag,
    output logic                                gcm_tag_valid,
    input  logic                                gcm_tag_stall,
    output kme_tlv_pkg::upsizer_beat_t          upsizer,
    output logic                                upsizer_valid,
    input  logic                                upsizer_stall,
    output logic [kme_tlv_pkg::TDATA_W-1:0]     sideband,
    output logic                                sideband_valid,
    input  logic                                sideband_stall
);

    logic beat_take;  // consumed-beat strobe from the router

    tlv_router u_router (
        .beat           (beat),
        .beat_valid     (beat_valid),
        .beat_ack       (beat_ack),
        .gcm_cmd_stall  (gcm_cmd_stall),
        .gcm_tag_stall  (gcm_tag_stall),
        .upsizer_stall  (upsizer_stall),
        .sideband_stall (sideband_stall),
        .beat_take      (beat_take),
        .upsizer        (upsizer),
        .upsizer_valid  (upsizer_valid),
        .sideband       (sideband),
        .sideband_valid (sideband_valid)
    );

    gcm_cmd_builder u_cmd_builder (
        .clk           (clk),
        .rst_n         (rst_n),
        .beat          (beat),
        .beat_take     (beat_take),
        .gcm_cmd       (gcm_cmd),
        .gcm_cmd_valid (gcm_cmd_valid)
    );

    gcm_tag_builder u_tag_builder (
        .clk           (clk),
        .rst_n         (rst_n),
        .beat          (beat),
        .beat_take     (beat_take),
        .gcm_tag       (gcm_tag),
        .gcm_tag_valid (gcm_tag_valid)
    );

endmodule

/* design/kme_tlv_pkg.sv */
// Shared widths, enums and beat structs for the KME TLV inspector.
// RTL and testbench refer to everything here by kme_tlv_pkg:: scoped names.
// Beat ids, key types and GCM ops follow the key-management engine encodings.
package kme_tlv_pkg;

    localparam int TDATA_W = 64;
    localparam int KEY_W   = 256;  // four beats per key field
    localparam int IV_W    = 96;
    localparam int TAG_W   = 96;
    localparam int ID_W    = 4;
    localparam int KTYPE_W = 4;
    localparam int OP_W    = 3;

    // tag carried with every upstream beat
    typedef enum logic [ID_W-1:0] {
        KME_WORD0    = 4'd0,
        KME_DEK_CKV0 = 4'd1,
        KME_DEK_CKV1 = 4'd2,
        KME_DAK_CKV  = 4'd3,
        KME_EIV      = 4'd4,
        KME_AIV      = 4'd5,
        KME_ETAG     = 4'd6,
        KME_ATAG     = 4'd7,
        KME_DEK0     = 4'd8,
        KME_DEK1     = 4'd9,
        KME_DAK      = 4'd10,
        KME_GUID     = 4'd11,
        KME_IVTWEAK  = 4'd12,
        KME_ERROR    = 4'd13,
        KME_OTHER    = 4'd14
    } tlv_id_e;

    typedef enum logic [KTYPE_W-1:0] {
        NO_AUX_KEY          = 4'd0,
        AUX_KEY_ONLY        = 4'd1,
        DEK256              = 4'd2,
        DEK512              = 4'd3,
        DAK                 = 4'd4,
        DEK256_DAK          = 4'd5,
        DEK512_DAK          = 4'd6,
        ENC_DEK256          = 4'd7,
        ENC_DEK512          = 4'd8,
        ENC_DAK             = 4'd9,
        ENC_DEK256_DAK      = 4'd10,
        ENC_DEK512_DAK      = 4'd11,
        ENC_DEK256_DAK_COMB = 4'd12,
        ENC_DEK512_DAK_COMB = 4'd13
    } key_type_e;

    typedef enum logic [OP_W-1:0] {
        PT_KEY_BLOB         = 3'd0,  // cleared command decodes to this
        PT_CKV              = 3'd1,
        DECRYPT_DEK256      = 3'd2,
        DECRYPT_DEK512      = 3'd3,
        DECRYPT_DAK         = 3'd4,
        DECRYPT_DEK256_COMB = 3'd5,
        DECRYPT_DEK512_COMB = 3'd6,
        DECRYPT_DAK_COMB    = 3'd7
    } gcm_op_e;

    typedef struct packed {
        tlv_id_e              id;
        logic                 eoi;  // last beat of this id
        logic [TDATA_W-1:0]   tdata;
    } tlv_beat_t;

    // word0 payload, only the key type is looked at
    typedef struct packed {
        logic [TDATA_W-KTYPE_W-1:0] rsvd;
        key_type_e                  key_type;
    } tlv_word0_t;

    typedef struct packed {
        gcm_op_e              op;
        logic [KEY_W-1:0]     key0;
        logic [KEY_W-1:0]     key1;
        logic [IV_W-1:0]      iv;
    } gcm_cmd_t;

    typedef struct packed {
        logic                 eof;
        logic [TDATA_W-1:0]   data;
    } upsizer_beat_t;

endpackage

/* design/tlv_router.sv */
// Per-beat steering for the TLV inspector.
// Forms the upstream ack from the beat id, eoi and the stall of the one output
// the beat can reach, and drives the upsizer and sideband passthrough beats.
// Fully combinational; builders only see beat_take.
`timescale 1ns/1ps

module tlv_router (
    input  kme_tlv_pkg::tlv_beat_t              beat,
    input  logic                                beat_valid,
    output logic                                beat_ack,
    input  logic                                gcm_cmd_stall,
    input  logic                                gcm_tag_stall,
    input  logic                                upsizer_stall,
    input  logic                                sideband_stall,
    output logic                                beat_take,
    output kme_tlv_pkg::upsizer_beat_t          upsizer,
    output logic                                upsizer_valid,
    output logic [kme_tlv_pkg::TDATA_W-1:0]     sideband,
    output logic                                sideband_valid
);

    logic is_key;     // dek0, dek1, dak go to the upsizer
    logic is_sb;      // word0, guid, ivtweak, error go to the sideband
    logic stall_hit;

    // classify the beat and pick the stall that applies to it
    always_comb begin
        is_key    = 1'b0;
        is_sb     = 1'b0;
        stall_hit = 1'b0;
        case (beat.id)
            kme_tlv_pkg::KME_DEK0,
            kme_tlv_pkg::KME_DEK1,
            kme_tlv_pkg::KME_DAK: begin
                is_key    = 1'b1;
                stall_hit = upsizer_stall;
            end
            // only the closing iv/tag beat produces an output
            kme_tlv_pkg::KME_EIV,
            kme_tlv_pkg::KME_AIV: begin
                stall_hit = beat.eoi & gcm_cmd_stall;
            end
            kme_tlv_pkg::KME_ETAG,
            kme_tlv_pkg::KME_ATAG: begin
                stall_hit = beat.eoi & gcm_tag_stall;
            end
            kme_tlv_pkg::KME_WORD0,
            kme_tlv_pkg::KME_GUID,
            kme_tlv_pkg::KME_IVTWEAK,
            kme_tlv_pkg::KME_ERROR: begin
                is_sb     = 1'b1;
                stall_hit = sideband_stall;
            end
            default: begin
                stall_hit = 1'b0;  // ckv beats and unknown ids never wait
            end
        endcase
    end

    assign beat_ack  = beat_valid & ~stall_hit;
    assign beat_take = beat_ack;  // builders load on every consumed beat

    // key passthrough, dek0 never closes a frame
    always_comb begin
        upsizer_valid = 1'b0;
        upsizer       = '0;
        if (beat_ack && is_key) begin
            upsizer_valid = 1'b1;
            upsizer.data  = beat.tdata;
            upsizer.eof   = (beat.id != kme_tlv_pkg::KME_DEK0) & beat.eoi;
        end
    end

    always_comb begin
        sideband_valid = 1'b0;
        sideband       = '0;
        if (beat_ack && is_sb) begin
            sideband_valid = 1'b1;
            sideband       = beat.tdata;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the TLV inspector testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module tb_kme_tlv_inspector -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

/* sim/tlv_tb_tasks.svh */
// Beat driving and reference tables for the TLV inspector testbench.
// Included inside the testbench module, so tasks see its signals directly.
// Callers start each send_beat on a falling clock edge.
`ifndef TLV_TB_TASKS_SVH
`define TLV_TB_TASKS_SVH

// expected dek and dak op for each key type code
localparam logic [2:0] DEK_OP_TBL [14] = '{3'd0, 3'd1, 3'd0, 3'd0, 3'd1, 3'd0, 3'd0,
                                           3'd2, 3'd3, 3'd1, 3'd2, 3'd3, 3'd5, 3'd6};
localparam logic [2:0] DAK_OP_TBL [14] = '{3'd0, 3'd1, 3'd1, 3'd1, 3'd0, 3'd0, 3'd0,
                                           3'd1, 3'd1, 3'd4, 3'd4, 3'd4, 3'd7, 3'd7};

// stall that may hold back the beat currently offered
function automatic logic rel_stall(input kme_tlv_pkg::tlv_beat_t b);
    case (b.id)
        kme_tlv_pkg::KME_DEK0, kme_tlv_pkg::KME_DEK1, kme_tlv_pkg::KME_DAK:
            return upsizer_stall;
        kme_tlv_pkg::KME_EIV, kme_tlv_pkg::KME_AIV:
            return b.eoi & gcm_cmd_stall;
        kme_tlv_pkg::KME_ETAG, kme_tlv_pkg::KME_ATAG:
            return b.eoi & gcm_tag_stall;
        kme_tlv_pkg::KME_WORD0, kme_tlv_pkg::KME_GUID,
        kme_tlv_pkg::KME_IVTWEAK, kme_tlv_pkg::KME_ERROR:
            return sideband_stall;
        default:
            return 1'b0;
    endcase
endfunction

task automatic shuffle_stalls();
    gcm_cmd_stall  = 1'($urandom_range(1, 0));
    gcm_tag_stall  = 1'($urandom_range(1, 0));
    upsizer_stall  = 1'($urandom_range(1, 0));
    sideband_stall = 1'($urandom_range(1, 0));
endtask

// offer one beat until acked and capture every output seen in that cycle
task automatic send_beat(input kme_tlv_pkg::tlv_id_e id, input logic eoi,
                         input logic [63:0] data);
    logic done;
    done = 1'b0;
    beat.id    = id;
    beat.eoi   = eoi;
    beat.tdata = data;
    beat_valid = 1'b1;
    if (stall_mode)
        shuffle_stalls();
    while (!done) begin
        #1;
        if (beat_ack) begin
            done      = 1'b1;
            got_cmd   = gcm_cmd;
            got_cmd_v = gcm_cmd_valid;
            got_tag   = gcm_tag;
            got_tag_v = gcm_tag_valid;
            got_up    = upsizer;
            got_up_v  = upsizer_valid;
            got_sb    = sideband;
            got_sb_v  = sideband_valid;
        end
        @(negedge clk);
        if (!done && stall_mode)
            shuffle_stalls();
    end
    beat_valid = 1'b0;
endtask

`endif

/* sim/tb_kme_tlv_inspector.sv */
// Testbench for the KME TLV inspector.
// Drives beats on the falling edge, samples outputs mid low phase, and checks
// them against expected values built from the beat format rules.
// Concurrent assertions watch the ack against the relevant stall throughout.
`timescale 1ns/1ps

module tb_kme_tlv_inspector;

    logic clk;
    logic rst_n;
    kme_tlv_pkg::tlv_beat_t beat;
    logic beat_valid, beat_ack;
    kme_tlv_pkg::gcm_cmd_t gcm_cmd;
    logic gcm_cmd_valid, gcm_cmd_stall;
    logic [95:0] gcm_tag;
    logic gcm_tag_valid, gcm_tag_stall;
    kme_tlv_pkg::upsizer_beat_t upsizer;
    logic upsizer_valid, upsizer_stall;
    logic [63:0] sideband;
    logic sideband_valid, sideband_stall;

    kme_tlv_pkg::gcm_cmd_t got_cmd;
    kme_tlv_pkg::upsizer_beat_t got_up;
    logic [95:0] got_tag;
    logic [63:0] got_sb;
    logic got_cmd_v, got_tag_v, got_up_v, got_sb_v;
    logic stall_mode;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;

    kme_tlv_inspector u_dut (.*);

    `include "tlv_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("timeout: run did not finish within 3000 cycles");
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ack_vs_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(beat_ack && rel_stall(beat)))
        else begin
            $display("ack given at %0t while the stall for id %0d was high", $time, beat.id);
            errors++;
        end

    no_valid_unacked: assert property (@(posedge clk) disable iff (!rst_n)
        beat_ack || !(gcm_cmd_valid | gcm_tag_valid | upsizer_valid | sideband_valid))
        else begin
            $display("an output valid rose at %0t on a beat that was not acked", $time);
            errors++;
        end

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    // only the closing iv beat may emit the command
    task automatic send_iv(input kme_tlv_pkg::tlv_id_e id, input logic [63:0] w0,
                           input logic [63:0] w1);
        send_beat(id, 1'b0, w0);
        check_val("gcm_cmd_valid", got_cmd_v, 0);
        send_beat(id, 1'b1, w1);
        check_val("gcm_cmd_valid", got_cmd_v, 1);
        check_val("gcm_cmd.iv", got_cmd.iv, {w0, w1[63:32]});
    endtask

    task automatic run_assembly();
        logic [63:0] k0 [4];
        logic [63:0] k1 [4];
        logic [63:0] kd [4];
        send_beat(kme_tlv_pkg::KME_WORD0, 1'b1, 64'd10);  // enc dek256 + dak
        foreach (k0[i]) begin
            k0[i] = {$urandom, $urandom};
            send_beat(kme_tlv_pkg::KME_DEK_CKV0, i == 3, k0[i]);
        end
        foreach (k1[i]) begin
            k1[i] = {$urandom, $urandom};
            send_beat(kme_tlv_pkg::KME_DEK_CKV1, i == 3, k1[i]);
        end
        foreach (kd[i]) begin
            kd[i] = {$urandom, $urandom};
            send_beat(kme_tlv_pkg::KME_DAK_CKV, i == 3, kd[i]);
        end
        send_iv(kme_tlv_pkg::KME_EIV, {$urandom, $urandom}, {$urandom, $urandom});
        check_val("dek key0", got_cmd.key0, {k0[0], k0[1], k0[2], k0[3]});
        check_val("dek key1", got_cmd.key1, {k1[0], k1[1], k1[2], k1[3]});
        check_val("dek op", got_cmd.op, 3'd2);
        send_iv(kme_tlv_pkg::KME_AIV, {$urandom, $urandom}, {$urandom, $urandom});
        check_val("dak key0", got_cmd.key0, {kd[0], kd[1], kd[2], kd[3]});
        check_val("dak key1", got_cmd.key1, {kd[0], kd[1], kd[2], kd[3]});
        send_beat(kme_tlv_pkg::KME_WORD0, 1'b1, 64'd10);
        send_iv(kme_tlv_pkg::KME_EIV, {$urandom, $urandom}, {$urandom, $urandom});
        check_val("cleared key0", got_cmd.key0, 0);
        check_val("cleared key1", got_cmd.key1, 0);
    endtask

    task automatic run_upsizer();
        logic [63:0] w;
        for (int i = 0; i < 6; i++) begin
            w = {$urandom, $urandom};
            send_beat(kme_tlv_pkg::tlv_id_e'(8 + i / 2), i[0], w);
            check_val("upsizer_valid", got_up_v, 1);
            check_val("upsizer.data", got_up.data, w);
            check_val("upsizer.eof", got_up.eof, (i / 2 == 0) ? 1'b0 : i[0]);
        end
    endtask

    initial begin
        logic [63:0] w0, w1;
        logic sb_exp;
        void'($urandom(15395));
        rst_n = 1'b0;
        beat = '0;
        beat_valid = 1'b0;
        {gcm_cmd_stall, gcm_tag_stall, upsizer_stall, sideband_stall} = '0;
        stall_mode = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int kt = 0; kt < 14; kt++) begin
            send_beat(kme_tlv_pkg::KME_WORD0, 1'b1, {$urandom, 28'd0, kt[3:0]});
            send_iv(kme_tlv_pkg::KME_EIV, {$urandom, $urandom}, {$urandom, $urandom});
            check_val("eiv op", got_cmd.op, DEK_OP_TBL[kt]);
            send_iv(kme_tlv_pkg::KME_AIV, {$urandom, $urandom}, {$urandom, $urandom});
            check_val("aiv op", got_cmd.op, DAK_OP_TBL[kt]);
        end
        end_test("key_type_decode");

        run_assembly();
        end_test("cmd_assembly");

        for (int t = 0; t < 2; t++) begin
            w0 = {$urandom, $urandom};
            w1 = {$urandom, $urandom};
            send_beat(t ? kme_tlv_pkg::KME_ATAG : kme_tlv_pkg::KME_ETAG, 1'b0, w0);
            check_val("gcm_tag_valid", got_tag_v, 0);
            send_beat(t ? kme_tlv_pkg::KME_ATAG : kme_tlv_pkg::KME_ETAG, 1'b1, w1);
            check_val("gcm_tag_valid", got_tag_v, 1);
            check_val("gcm_tag", got_tag, {w0, w1[63:32]});
        end
        end_test("tag_assembly");

        run_upsizer();
        end_test("upsizer_passthrough");

        for (int id = 0; id < 15; id++) begin
            w0 = {$urandom, $urandom};
            sb_exp = (id == 0) || (id >= 11 && id <= 13);  // word0, guid, ivtweak, error
            send_beat(kme_tlv_pkg::tlv_id_e'(id), 1'b0, w0);
            check_val("sideband_valid", got_sb_v, sb_exp);
            if (sb_exp)
                check_val("sideband", got_sb, w0);
        end
        end_test("sideband_passthrough");

        // eiv without eoi passes the command stall while the closing beat waits
        gcm_cmd_stall = 1'b1;
        beat = '{kme_tlv_pkg::KME_EIV, 1'b0, 64'h1234};
        beat_valid = 1'b1;
        #1 check_val("beat_ack", beat_ack, 1);
        @(negedge clk);
        beat.eoi = 1'b1;
        #1 check_val("beat_ack", beat_ack, 0);
        check_val("gcm_cmd_valid", gcm_cmd_valid, 0);
        @(negedge clk);
        gcm_cmd_stall = 1'b0;
        send_beat(kme_tlv_pkg::KME_EIV, 1'b1, 64'h5678_0000_0000);
        check_val("gcm_cmd_valid", got_cmd_v, 1);
        stall_mode = 1'b1;
        run_assembly();
        run_upsizer();
        stall_mode = 1'b0;
        {gcm_cmd_stall, gcm_tag_stall, upsizer_stall, sideband_stall} = '0;
        end_test("back_pressure");

        repeat (2) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
